// ==== bchDecoder.f ====
+incdir+include
source/bchPkg.sv
source/gfMultiplier.sv
source/syndromeUnit.sv
source/errorLocator.sv
source/chienSearch.sv
source/decoderControl.sv
source/bchDecoderTop.sv
sim/bchDecoderTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module bchDecoderTb -f bchDecoder.f -o bchDecoderSim

./obj_dir/bchDecoderSim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
	echo "run ok"
else
	echo "run not ok, see sim.log"
	exit 1
fi

// ==== sim/decoderInput.txt ====
# received  expected  count  uncorrectable
# words in hex, bit 14 first on the wire; count and flag in decimal
0000 0000 0 0
0537 0537 0 0
7FFF 7FFF 0 0
47AC 47AC 0 0
0536 0537 1 0
4A6E 0A6E 1 0
2D8F 2C8F 1 0
54DD 14DC 2 0
635D 614D 2 0
0081 0000 2 0
68BA 29B8 3 0
5377 5370 3 0
5BF7 7FFF 3 0
1779 0F59 3 0
000F 000F 0 1
7FF0 7FF0 0 1
05C7 05C7 0 1
3FAC 3FAC 0 1
4A69 4A69 0 1
0A6E 0A6E 0 0

// ==== sim/bchDecoderTb.sv ====
module bchDecoderTb
	import bchPkg::*;
();

	localparam int MAX_VECTORS = 64;

	logic clk;
	logic reset;
	logic inReq;
	decodeRequest inData;
	logic inAck;
	logic outReq;
	decodeResult outData;
	logic outAck;

	codeWord rxWord [MAX_VECTORS];
	codeWord expWord [MAX_VECTORS];
	errCount expCount [MAX_VECTORS];
	logic expFlag [MAX_VECTORS];
	int numVectors;
	int valueErrors;
	int protocolErrors;
	int setupErrors;
	int cycleCount;
	int cycleLimit;
	int seed;
	logic prevInReq;
	logic prevInAck;
	logic prevOutReq;
	logic prevOutAck;

	bchDecoderTop dut (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.outReq(outReq),
		.outData(outData),
		.outAck(outAck)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("timeout after %0d cycles, a handshake never completed", cycleCount);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// four-phase rules, sampled values from before the edge
	always @(posedge clk) begin
		if (!reset) begin
			if (inAck && !prevInAck && !prevInReq) begin
				$display("t=%0t inAck rose while inReq was low", $time);
				protocolErrors++;
			end
			if (outReq && !prevOutReq && inAck) begin
				$display("t=%0t outReq rose before inAck had fallen", $time);
				protocolErrors++;
			end
			if (!outReq && prevOutReq && !prevOutAck) begin
				$display("t=%0t outReq fell without outAck", $time);
				protocolErrors++;
			end
		end
		prevInReq = inReq;
		prevInAck = inAck;
		prevOutReq = outReq;
		prevOutAck = outAck;
	end

	task automatic loadVectors();
		int fd;
		int fields;
		string line;
		logic [15:0] rx;
		logic [15:0] ex;
		int cnt;
		int flag;
		numVectors = 0;
		fd = $fopen("sim/decoderInput.txt", "r");
		if (fd == 0) begin
			$display("could not open sim/decoderInput.txt");
			setupErrors++;
		end else begin
			while (!$feof(fd) && numVectors < MAX_VECTORS) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() >= 4 && line.getc(0) != "#") begin	// skip blanks and notes
					fields = $sscanf(line, "%h %h %d %d", rx, ex, cnt, flag);
					if (fields == 4) begin
						rxWord[numVectors] = rx[14:0];
						expWord[numVectors] = ex[14:0];
						expCount[numVectors] = cnt[1:0];
						expFlag[numVectors] = flag[0];
						numVectors++;
					end else begin
						$display("malformed line in vector file: %s", line);
						setupErrors++;
					end
				end
			end
			$fclose(fd);
		end
		if (numVectors == 0) begin
			$display("no test vectors were read");
			setupErrors++;
		end
	endtask

	task automatic sendWord(input codeWord word);
		@(posedge clk);
		#1;
		inData.word = word;
		inReq = 1'b1;
		@(posedge clk);
		while (!inAck)
			@(posedge clk);
		#1;
		inReq = 1'b0;
		@(posedge clk);
		while (inAck)
			@(posedge clk);
	endtask

	task automatic checkHeld(input decodeResult first);
		if (outData !== first) begin
			$display("FAIL t=%0t outData got %h expected %h (changed under back-pressure)",
				$time, outData, first);
			valueErrors++;
		end
	endtask

	task automatic compareResult(input int idx, input decodeResult got);
		if (got.word !== expWord[idx]) begin
			$display("FAIL t=%0t outData.word vector %0d got %h expected %h",
				$time, idx, got.word, expWord[idx]);
			valueErrors++;
		end
		if (got.count !== expCount[idx]) begin
			$display("FAIL t=%0t outData.count vector %0d got %0d expected %0d",
				$time, idx, got.count, expCount[idx]);
			valueErrors++;
		end
		if (got.uncorrectable !== expFlag[idx]) begin
			$display("FAIL t=%0t outData.uncorrectable vector %0d got %b expected %b",
				$time, idx, got.uncorrectable, expFlag[idx]);
			valueErrors++;
		end
	endtask

	task automatic collectResult(input int idx);
		decodeResult first;
		int randVal;
		int waitCycles;
		@(posedge clk);
		while (!outReq)
			@(posedge clk);
		first = outData;	// must hold until outReq drops
		randVal = $random(seed);
		waitCycles = randVal & 7;
		repeat (waitCycles) begin
			@(posedge clk);
			checkHeld(first);
		end
		#1;
		outAck = 1'b1;
		@(posedge clk);
		while (outReq) begin
			checkHeld(first);
			@(posedge clk);
		end
		#1;
		outAck = 1'b0;
		compareResult(idx, first);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		seed = 78;
		valueErrors = 0;
		protocolErrors = 0;
		setupErrors = 0;
		cycleCount = 0;
		cycleLimit = 100;
		prevInReq = 1'b0;
		prevInAck = 1'b0;
		prevOutReq = 1'b0;
		prevOutAck = 1'b0;
		loadVectors();
		cycleLimit = 60 * numVectors + 100;

		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		if (inAck !== 1'b0) begin
			$display("FAIL t=%0t inAck got %b expected 0 after reset", $time, inAck);
			valueErrors++;
		end
		if (outReq !== 1'b0) begin
			$display("FAIL t=%0t outReq got %b expected 0 after reset", $time, outReq);
			valueErrors++;
		end

		// source runs ahead, so each word waits for the previous response
		fork
			begin : sourceSide
				for (int i = 0; i < numVectors; i++)
					sendWord(rxWord[i]);
			end
			begin : sinkSide
				for (int j = 0; j < numVectors; j++)
					collectResult(j);
			end
		join

		repeat (4) @(posedge clk);
		$display("errors: %0d value, %0d protocol, %0d setup over %0d vectors",
			valueErrors, protocolErrors, setupErrors, numVectors);
		if (valueErrors + protocolErrors + setupErrors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== source/bchDecoderTop.sv ====
module bchDecoderTop
	import bchPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inReq,
	input decodeRequest inData,
	output logic inAck,
	output logic outReq,
	output decodeResult outData,
	input logic outAck
);

	logic bitIn;
	logic bitValid;
	logic synLoad;
	logic iterStep;
	logic discLoad;
	logic stepSel;
	logic searchStart;
	logic searchStep;
	logic discNonZero;
	codeWord held;
	syndromeVec syndromes;
	logic [19:0] winOut;
	locatorPoly locator;

	decoderControl uControl (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.outReq(outReq),
		.outAck(outAck),
		.discNonZero(discNonZero),
		.bitIn(bitIn),
		.bitValid(bitValid),
		.synLoad(synLoad),
		.iterStep(iterStep),
		.discLoad(discLoad),
		.stepSel(stepSel),
		.searchStart(searchStart),
		.searchStep(searchStep),
		.held(held)
	);

	syndromeUnit uSyndrome (
		.clk(clk),
		.reset(reset),
		.bitIn(bitIn),
		.bitValid(bitValid),
		.synLoad(synLoad),
		.iterStep(iterStep),
		.syndromes(syndromes),
		.winOut(winOut)
	);

	errorLocator uLocator (
		.clk(clk),
		.reset(reset),
		.synLoad(synLoad),
		.iterStep(iterStep),
		.discLoad(discLoad),
		.stepSel(stepSel),
		.syn1(syndromes[3:0]),	// S1 seeds c1
		.window(winOut),
		.locator(locator),
		.discNonZero(discNonZero)
	);

	chienSearch uChien (
		.clk(clk),
		.reset(reset),
		.searchStart(searchStart),
		.searchStep(searchStep),
		.locator(locator),
		.received(held),
		.result(outData)
	);

endmodule

// ==== source/decoderControl.sv ====
`include "bch_defs.svh"

module decoderControl
	import bchPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inReq,
	input decodeRequest inData,
	output logic inAck,
	output logic outReq,
	input logic outAck,
	input logic discNonZero,
	output logic bitIn,
	output logic bitValid,
	output logic synLoad,
	output logic iterStep,
	output logic discLoad,
	output logic stepSel,
	output logic searchStart,
	output logic searchStep,
	output codeWord held
);

	ctrlState state;
	logic [3:0] stepCnt;
	logic [2:0] locLen;	// current locator length L
	logic [2:0] iterIdx;	// BM iteration r, 1 or 2
	logic accept;

	assign accept = (state == IDLE) && inReq && !inAck;

	always_comb begin
		bitValid = state == SYNDROME;
		bitIn = held[stepCnt];	// counts down from 14, MSB first
		synLoad = state == LOAD;
		discLoad = (state == ITERATE) && !stepCnt[0];
		iterStep = (state == ITERATE) && stepCnt[0];
		iterIdx = {2'b00, stepCnt[1]} + 3'd1;
		// take the old locator when d != 0 and 2L <= 2r
		stepSel = iterStep && discNonZero && (locLen <= iterIdx);
		searchStart = (state == SEARCH) && (stepCnt == 4'd0);
		searchStep = (state == SEARCH) && (stepCnt != 4'd0);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			inAck <= 1'b0;
			outReq <= 1'b0;
			stepCnt <= '0;
			locLen <= '0;
		end else begin
			if (inAck && !inReq)	// source let go, close the input handshake
				inAck <= 1'b0;

			case (state)
				IDLE: begin
					if (accept) begin
						inAck <= 1'b1;
						stepCnt <= 4'd14;
						state <= SYNDROME;
					end
				end
				SYNDROME: begin
					if (stepCnt == 4'd0)
						state <= LOAD;
					else
						stepCnt <= stepCnt - 4'd1;
				end
				LOAD: begin
					locLen <= discNonZero ? 3'd1 : 3'd0;
					stepCnt <= '0;
					state <= ITERATE;
				end
				ITERATE: begin
					if (stepSel)
						locLen <= {iterIdx[1:0], 1'b1} - locLen;	// L = 2r+1-L
					if (stepCnt == 4'd3) begin
						stepCnt <= '0;
						state <= SEARCH;
					end else begin
						stepCnt <= stepCnt + 4'd1;
					end
				end
				SEARCH: begin
					if (stepCnt == 4'd15) begin	// result lands on this same edge
						outReq <= 1'b1;
						state <= RESPOND;
					end else begin
						stepCnt <= stepCnt + 4'd1;
					end
				end
				RESPOND: begin
					if (outAck) begin
						outReq <= 1'b0;
						state <= RELEASE;
					end
				end
				RELEASE: begin
					if (!outAck)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			held <= inData.word;
	end

	// sink must have acknowledged before the request is withdrawn
	assert property (@(posedge clk) disable iff (reset) $fell(outReq) |-> $past(outAck));

endmodule

// ==== source/chienSearch.sv ====
`include "bch_defs.svh"

module chienSearch
	import bchPkg::*;
(
	input logic clk,
	input logic reset,
	input logic searchStart,
	input logic searchStep,
	input locatorPoly locator,
	input codeWord received,
	output decodeResult result
);

	gfElem term0;	// c0 does not move
	gfElem term1;
	gfElem term2;
	gfElem term3;
	gfElem prod1;
	gfElem prod2;
	gfElem prod3;
	codeWord work;
	logic [3:0] pos;	// bit under test
	logic [3:0] rootCnt;
	logic isRoot;
	logic [3:0] nextCnt;
	codeWord nextWord;
	logic [1:0] degree;
	logic mismatch;

	gfMultiplier uStep1 (.a(term1), .b(4'b0010), .product(prod1));
	gfMultiplier uStep2 (.a(term2), .b(4'b0100), .product(prod2));
	gfMultiplier uStep3 (.a(term3), .b(4'b1000), .product(prod3));

	always_comb begin
		isRoot = (term0 ^ prod1 ^ prod2 ^ prod3) == '0;	// step k tests alpha^k, bit 15-k
		nextCnt = rootCnt + {3'b000, isRoot};
		nextWord = work;
		if (isRoot)
			nextWord[pos] = ~work[pos];
		// terms only get scaled by nonzero powers, so zeros stay zeros
		if (term3 != '0)
			degree = 2'd3;
		else if (term2 != '0)
			degree = 2'd2;
		else if (term1 != '0)
			degree = 2'd1;
		else
			degree = 2'd0;
		mismatch = nextCnt != {2'b00, degree};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pos <= '0;
			rootCnt <= '0;
		end else if (searchStart) begin
			pos <= 4'd14;
			rootCnt <= '0;
		end else if (searchStep) begin
			pos <= pos - 4'd1;
			rootCnt <= nextCnt;
		end
	end

	always_ff @(posedge clk) begin
		if (searchStart) begin
			term0 <= locator[0 +: `GF_M];
			term1 <= locator[`GF_M +: `GF_M];
			term2 <= locator[2*`GF_M +: `GF_M];
			term3 <= locator[3*`GF_M +: `GF_M];
			work <= received;
		end else if (searchStep) begin
			term1 <= prod1;
			term2 <= prod2;
			term3 <= prod3;
			work <= nextWord;
			if (pos == 4'd0) begin	// last bit, settle the verdict
				result.word <= mismatch ? received : nextWord;
				result.count <= mismatch ? 2'd0 : nextCnt[1:0];
				result.uncorrectable <= mismatch;
			end
		end
	end

endmodule

// ==== source/errorLocator.sv ====
`include "bch_defs.svh"

module errorLocator
	import bchPkg::*;
(
	input logic clk,
	input logic reset,
	input logic synLoad,
	input logic iterStep,
	input logic discLoad,
	input logic stepSel,
	input gfElem syn1,
	input logic [19:0] window,
	output locatorPoly locator,
	output logic discNonZero
);

	gfElem coef [`BCH_T+1];	// locator c0..c3
	gfElem aux2;	// x*B(x), only the x^2 and x^3 terms survive
	gfElem aux3;
	gfElem gamma;	// previous discrepancy
	gfElem disc;	// current discrepancy
	gfElem synProd [`BCH_T+1];
	gfElem gamProd [`BCH_T+1];
	gfElem auxProd2;
	gfElem auxProd3;
	gfElem discSum;

	genvar i;

	generate
		for (i = 0; i <= `BCH_T; i++) begin : coefMul
			gfMultiplier uSynMul (
				.a(coef[i]),
				.b(window[i*`GF_M +: `GF_M]),
				.product(synProd[i])
			);
			gfMultiplier uGamMul (
				.a(coef[i]),
				.b(gamma),
				.product(gamProd[i])
			);
		end
	endgenerate

	gfMultiplier uAuxMul2 (.a(disc), .b(aux2), .product(auxProd2));
	gfMultiplier uAuxMul3 (.a(disc), .b(aux3), .product(auxProd3));

	always_comb begin
		discSum = '0;
		for (int k = 0; k <= `BCH_T; k++)
			discSum = discSum ^ synProd[k];
	end

	// during synLoad the first discrepancy is S1 itself
	assign discNonZero = synLoad ? |syn1 : |disc;

	always_ff @(posedge clk) begin
		if (discLoad)
			disc <= discSum;

		if (synLoad) begin	// first iteration folded into the load
			coef[0] <= 4'd1;
			coef[1] <= syn1;
			coef[2] <= '0;
			coef[3] <= '0;
		end else if (iterStep) begin	// gamma*C(x) + d*x*B(x)
			coef[0] <= gamProd[0];
			coef[1] <= gamProd[1];
			coef[2] <= gamProd[2] ^ auxProd2;
			coef[3] <= gamProd[3] ^ auxProd3;
		end

		if (synLoad) begin
			gamma <= (|syn1) ? syn1 : 4'd1;
			aux2 <= {3'b000, |syn1};	// B = x
			aux3 <= {3'b000, ~|syn1};	// B = x^2
		end else if (iterStep) begin
			if (stepSel) begin
				gamma <= disc;
				aux2 <= coef[0];	// x^2 * old C(x)
				aux3 <= coef[1];
			end else begin
				aux2 <= '0;	// x^2 * B pushes past degree 3
				aux3 <= '0;
			end
		end
	end

	assign locator = {coef[3], coef[2], coef[1], coef[0]};

	// an update on top of a fresh load would mix two words
	assert property (@(posedge clk) disable iff (reset) !(iterStep && synLoad));

endmodule

// ==== source/syndromeUnit.sv ====
`include "bch_defs.svh"

module syndromeUnit
	import bchPkg::*;
(
	input logic clk,
	input logic reset,
	input logic bitIn,
	input logic bitValid,
	input logic synLoad,
	input logic iterStep,
	output syndromeVec syndromes,
	output logic [19:0] winOut
);

	gfElem acc1;	// S1 accumulator
	gfElem acc3;	// S3 accumulator
	gfElem acc5;	// S5 accumulator
	gfElem mul1;
	gfElem mul3;
	gfElem mul5;
	gfElem syn2;
	gfElem syn4;
	gfElem syn6;
	gfElem win [5];

	// squaring is linear in GF(2^4)
	function automatic gfElem gfSquare(input gfElem x);
		gfSquare = {x[3], x[1] ^ x[3], x[2], x[0] ^ x[2]};
	endfunction

	gfMultiplier uMulA1 (.a(acc1), .b(4'b0010), .product(mul1));	// alpha
	gfMultiplier uMulA3 (.a(acc3), .b(4'b1000), .product(mul3));	// alpha^3
	gfMultiplier uMulA5 (.a(acc5), .b(4'b0110), .product(mul5));	// alpha^5

	// Horner's rule, one received bit per cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			acc1 <= '0;
			acc3 <= '0;
			acc5 <= '0;
		end else if (synLoad) begin	// engine has taken them, ready for next word
			acc1 <= '0;
			acc3 <= '0;
			acc5 <= '0;
		end else if (bitValid) begin
			acc1 <= mul1 ^ {3'b000, bitIn};
			acc3 <= mul3 ^ {3'b000, bitIn};
			acc5 <= mul5 ^ {3'b000, bitIn};
		end
	end

	assign syn2 = gfSquare(acc1);
	assign syn4 = gfSquare(syn2);
	assign syn6 = gfSquare(acc3);

	assign syndromes = {syn6, acc5, syn4, acc3, syn2, acc1};

	// slots 0..3 face c0..c3; slot 4 is parked for the next rotation.
	// First iteration sees S3,S2 against c0,c1 while c2,c3 are still zero,
	// and a rotation by two brings S5,S4,S3,S2 into place for the second.
	always_ff @(posedge clk) begin
		if (synLoad) begin
			win[0] <= acc3;
			win[1] <= syn2;
			win[2] <= acc1;
			win[3] <= acc5;
			win[4] <= syn4;
		end else if (iterStep) begin
			win[0] <= win[3];
			win[1] <= win[4];
			win[2] <= win[0];
			win[3] <= win[1];
			win[4] <= win[2];
		end
	end

	assign winOut = {win[4], win[3], win[2], win[1], win[0]};

	// the window would load a half-accumulated syndrome
	assert property (@(posedge clk) disable iff (reset) !(bitValid && synLoad));

endmodule

// ==== source/gfMultiplier.sv ====
`include "bch_defs.svh"

module gfMultiplier
	import bchPkg::*;
(
	input gfElem a,
	input gfElem b,
	output gfElem product
);

	gfElem acc;
	gfElem shifted;

	// shift and add, reducing whenever the top bit falls off
	always_comb begin
		acc = '0;
		shifted = a;
		for (int i = 0; i < `GF_M; i++) begin
			if (b[i])
				acc = acc ^ shifted;
			if (shifted[`GF_M-1])
				shifted = {shifted[`GF_M-2:0], 1'b0} ^ `GF_POLY;
			else
				shifted = {shifted[`GF_M-2:0], 1'b0};
		end
	end

	assign product = acc;

endmodule

// ==== source/bchPkg.sv ====
`include "bch_defs.svh"

package bchPkg;

	typedef logic [`GF_M-1:0] gfElem;	// one field element
	typedef logic [`BCH_N-1:0] codeWord;	// bit 14 goes first on the wire
	typedef logic [2*`BCH_T*`GF_M-1:0] syndromeVec;	// S1 in the low nibble
	typedef logic [(`BCH_T+1)*`GF_M-1:0] locatorPoly;	// c0 in the low nibble
	typedef logic [1:0] errCount;

	typedef struct packed {
		codeWord word;
	} decodeRequest;

	typedef struct packed {
		codeWord word;
		errCount count;
		logic uncorrectable;
	} decodeResult;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		SYNDROME,
		ITERATE,
		SEARCH,
		RESPOND,
		RELEASE
	} ctrlState;

endpackage

// ==== include/bch_defs.svh ====
`ifndef BCH_DEFS_SVH
`define BCH_DEFS_SVH

// GF(2^4) built on x^4 + x + 1
`define GF_M 4

// correctable bit errors
`define BCH_T 3

// code length 2^m - 1
`define BCH_N 15

// low bits of the field polynomial, x^4 implied
`define GF_POLY 4'b0011

`endif
